// File: logic/hv_reg_pkg.sv
package hv_reg_pkg;

    // ==================================================
    // register port widths
    // ==================================================
    localparam int REG_AW = 4;
    localparam int REG_DW = 8;

    typedef logic [REG_DW-1:0] reg_data_t;

    // ==================================================
    // register map
    // ==================================================
    localparam logic [REG_AW-1:0] ADDR_MODE       = 4'd0;
    localparam logic [REG_AW-1:0] ADDR_COM_CFG    = 4'd1; // low six bits mask fault irq
    localparam logic [REG_AW-1:0] ADDR_STATUS_FLT = 4'd2; // w1c
    localparam logic [REG_AW-1:0] ADDR_CTRL_ST    = 4'd3; // read only
    localparam logic [REG_AW-1:0] ADDR_SCRATCH    = 4'd4;

    // decoded operation
    typedef enum logic [2:0] {
        ACC_NONE       = 3'd0,
        ACC_WR_MODE    = 3'd1,
        ACC_WR_CFG     = 3'd2,
        ACC_CLR_FLT    = 3'd3,
        ACC_WR_SCRATCH = 3'd4,
        ACC_RD         = 3'd5,
        ACC_ERR        = 3'd6
    } reg_acc_kind_e;

    typedef struct packed {
        logic [3:0] rsvd;      // read back as written
        logic       bist_en;   // storage only
        logic       reset_en;  // storage only
        logic       cfg_en;
        logic       normal_en;
    } reg_mode_t;

endpackage

// File: logic/hv_ctrl_pkg.sv
package hv_ctrl_pkg;

    localparam int FLT_NUM = 6;

    // fault bit order maps to status register bits 2..7
    localparam int FLT_VCC_UV = 0;
    localparam int FLT_VCC_OV = 1;
    localparam int FLT_OT     = 2;
    localparam int FLT_OC     = 3;
    localparam int FLT_DESAT  = 4;
    localparam int FLT_SCP    = 5;

    typedef logic [FLT_NUM-1:0] flt_vec_t;

    // control state as read in bits 7:4 of ctrl state reg
    typedef enum logic [3:0] {
        ST_RESET  = 4'd0,
        ST_WAIT   = 4'd1,
        ST_CFG    = 4'd2,
        ST_NORMAL = 4'd3,
        ST_FAULT  = 4'd4
    } ctrl_st_e;

endpackage

// File: logic/hv_core_if.sv
`timescale 1ns/1ps

// decoded request from decode to bank
interface reg_access_if import hv_reg_pkg::*; ();

    logic                vld;
    reg_acc_kind_e       kind;
    logic [REG_AW-1:0]   addr;
    reg_data_t           wdata;

    modport decode (output vld, output kind, output addr, output wdata);
    modport bank   (input  vld, input  kind, input  addr, input  wdata);

endinterface

// registered response from bank to result
interface reg_rsp_if import hv_reg_pkg::*; ();

    logic                vld;
    logic                is_rd;
    reg_data_t           rdata;
    logic                err;

    modport bank   (output vld, output is_rd, output rdata, output err);
    modport result (input  vld, input  is_rd, input  rdata, input  err);

endinterface

// File: logic/hv_reg_decode.sv
`timescale 1ns/1ps

module hv_reg_decode import hv_reg_pkg::*; (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_wr_req,
    input  logic                i_rd_req,
    input  logic [REG_AW-1:0]   i_addr,
    input  reg_data_t           i_wdata,
    reg_access_if.decode        o_acc
);

    reg_acc_kind_e kind_d;

    // write wins when both strobes are high
    always_comb begin
        kind_d = ACC_NONE;
        if (i_wr_req) begin
            case (i_addr)
                ADDR_MODE:       kind_d = ACC_WR_MODE;
                ADDR_COM_CFG:    kind_d = ACC_WR_CFG;
                ADDR_STATUS_FLT: kind_d = ACC_CLR_FLT;
                ADDR_SCRATCH:    kind_d = ACC_WR_SCRATCH;
                default:         kind_d = ACC_ERR; // ctrl state or unmapped
            endcase
        end else if (i_rd_req) begin
            kind_d = ACC_RD; // unmapped reads caught at the bank read mux
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_acc.vld  <= 1'b0;
            o_acc.kind <= ACC_NONE;
        end else begin
            o_acc.vld  <= i_wr_req | i_rd_req;
            o_acc.kind <= kind_d;
        end
    end

    always_ff @(posedge i_clk) begin
        o_acc.addr  <= i_addr;
        o_acc.wdata <= i_wdata;
    end

endmodule

// File: logic/hv_fault_filter.sv
`timescale 1ns/1ps

module hv_fault_filter import hv_ctrl_pkg::*; #(
    parameter int FLT_FILT_CYC = 4
) (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_hv_vcc_uv,
    input  logic        i_hv_vcc_ov,
    input  logic        i_hv_ot,
    input  logic        i_hv_oc,
    input  logic        i_hv_desat_flt,
    input  logic        i_hv_scp_flt,
    output flt_vec_t    o_flt
);

    localparam int CNT_W = $clog2(FLT_FILT_CYC + 1);

    flt_vec_t           flt_raw;
    flt_vec_t           sync_q1;
    flt_vec_t           sync_q2;
    logic [CNT_W-1:0]   cnt_q [FLT_NUM];

    assign flt_raw[FLT_VCC_UV] = i_hv_vcc_uv;
    assign flt_raw[FLT_VCC_OV] = i_hv_vcc_ov;
    assign flt_raw[FLT_OT]     = i_hv_ot;
    assign flt_raw[FLT_OC]     = i_hv_oc;
    assign flt_raw[FLT_DESAT]  = i_hv_desat_flt;
    assign flt_raw[FLT_SCP]    = i_hv_scp_flt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            for (int i = 0; i < FLT_NUM; i++) cnt_q[i] <= '0;
        end else begin
            sync_q1 <= flt_raw; // async analog comparators
            sync_q2 <= sync_q1;
            for (int i = 0; i < FLT_NUM; i++) begin
                if (!sync_q2[i])
                    cnt_q[i] <= '0;
                else if (cnt_q[i] != CNT_W'(FLT_FILT_CYC))
                    cnt_q[i] <= cnt_q[i] + 1'b1; // saturate at threshold
            end
        end
    end

    always_comb begin
        for (int i = 0; i < FLT_NUM; i++) o_flt[i] = (cnt_q[i] == CNT_W'(FLT_FILT_CYC));
    end

endmodule

// File: logic/hv_reg_bank.sv
`timescale 1ns/1ps

module hv_reg_bank import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic            i_clk,
    input  logic            i_reset,
    reg_access_if.bank      i_acc,
    input  flt_vec_t        i_flt,
    input  ctrl_st_e        i_ctrl_st,
    reg_rsp_if.bank         o_rsp,
    output reg_mode_t       o_mode,
    output flt_vec_t        o_flt_latched,
    output flt_vec_t        o_flt_mask
);

    reg_mode_t  mode_q;
    reg_data_t  cfg_q;
    flt_vec_t   flt_q;
    reg_data_t  scratch_q;

    flt_vec_t   flt_clr;
    reg_data_t  rd_data;
    logic       rd_unmapped;

    // ==================================================
    // register storage
    // ==================================================
    assign flt_clr = (i_acc.vld && i_acc.kind == ACC_CLR_FLT) ?
                     i_acc.wdata[REG_DW-1:REG_DW-FLT_NUM] : '0;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            mode_q    <= '0;
            cfg_q     <= '0;
            flt_q     <= '0;
            scratch_q <= '0;
        end else begin
            flt_q <= (flt_q & ~flt_clr) | i_flt; // set beats clear
            if (i_acc.vld && i_acc.kind == ACC_WR_MODE)    mode_q    <= reg_mode_t'(i_acc.wdata);
            if (i_acc.vld && i_acc.kind == ACC_WR_CFG)     cfg_q     <= i_acc.wdata;
            if (i_acc.vld && i_acc.kind == ACC_WR_SCRATCH) scratch_q <= i_acc.wdata;
        end
    end

    // ==================================================
    // read mux
    // ==================================================
    always_comb begin
        rd_data     = '0;
        rd_unmapped = 1'b0;
        if (i_acc.kind == ACC_RD) begin
            case (i_acc.addr)
                ADDR_MODE:       rd_data = reg_data_t'(mode_q);
                ADDR_COM_CFG:    rd_data = cfg_q;
                ADDR_STATUS_FLT: rd_data = {flt_q, {(REG_DW-FLT_NUM){1'b0}}};
                ADDR_CTRL_ST:    rd_data = {i_ctrl_st, 4'b0000};
                ADDR_SCRATCH:    rd_data = scratch_q;
                default:         rd_unmapped = 1'b1; // data stays 0
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rsp.vld   <= 1'b0;
            o_rsp.is_rd <= 1'b0;
            o_rsp.err   <= 1'b0;
        end else begin
            o_rsp.vld   <= i_acc.vld;
            o_rsp.is_rd <= i_acc.vld && i_acc.kind == ACC_RD;
            o_rsp.err   <= i_acc.vld && (i_acc.kind == ACC_ERR || rd_unmapped);
        end
    end

    always_ff @(posedge i_clk) begin
        o_rsp.rdata <= rd_data;
    end

    assign o_mode        = mode_q;
    assign o_flt_latched = flt_q;
    assign o_flt_mask    = cfg_q[FLT_NUM-1:0];

endmodule

// File: logic/hv_ctrl_fsm.sv
`timescale 1ns/1ps

module hv_ctrl_fsm import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  reg_mode_t   i_mode,
    input  flt_vec_t    i_flt_latched,
    output ctrl_st_e    o_ctrl_st,
    output logic        o_pwm_en
);

    ctrl_st_e   st_q;
    ctrl_st_e   st_d;
    logic       pwm_q;

    // mask only affects the interrupt, never the state
    always_comb begin
        if (st_q == ST_RESET)
            st_d = ST_WAIT;
        else if (|i_flt_latched)
            st_d = ST_FAULT;
        else if (i_mode.normal_en)
            st_d = ST_NORMAL;
        else if (i_mode.cfg_en)
            st_d = ST_CFG;
        else
            st_d = ST_WAIT;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            st_q  <= ST_RESET;
            pwm_q <= 1'b0;
        end else begin
            st_q  <= st_d;
            pwm_q <= (st_d == ST_NORMAL); // tracks state register exactly
        end
    end

    assign o_ctrl_st = st_q;
    assign o_pwm_en  = pwm_q;

endmodule

// File: logic/hv_rsp_result.sv
`timescale 1ns/1ps

module hv_rsp_result import hv_reg_pkg::*; import hv_ctrl_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    reg_rsp_if.result   i_rsp,
    input  flt_vec_t    i_flt_latched,
    input  flt_vec_t    i_flt_mask,
    output logic        o_wr_ack,
    output logic        o_rd_ack,
    output reg_data_t   o_rdata,
    output logic        o_addr_err,
    output logic        o_intb_n
);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wr_ack   <= 1'b0;
            o_rd_ack   <= 1'b0;
            o_addr_err <= 1'b0;
            o_intb_n   <= 1'b1;
        end else begin
            o_wr_ack   <= i_rsp.vld & ~i_rsp.is_rd;
            o_rd_ack   <= i_rsp.vld &  i_rsp.is_rd;
            o_addr_err <= i_rsp.vld &  i_rsp.err;
            o_intb_n   <= ~|(i_flt_latched & ~i_flt_mask); // active low
        end
    end

    // hold last read value between acks
    always_ff @(posedge i_clk) begin
        if (i_rsp.vld && i_rsp.is_rd) o_rdata <= i_rsp.rdata;
    end

endmodule

// File: logic/hv_core.sv
`timescale 1ns/1ps

module hv_core import hv_reg_pkg::*; import hv_ctrl_pkg::*; #(
    parameter int FLT_FILT_CYC = 4
) (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_wr_req,
    input  logic                i_rd_req,
    input  logic [REG_AW-1:0]   i_addr,
    input  reg_data_t           i_wdata,
    input  logic                i_hv_vcc_uv,
    input  logic                i_hv_vcc_ov,
    input  logic                i_hv_ot,
    input  logic                i_hv_oc,
    input  logic                i_hv_desat_flt,
    input  logic                i_hv_scp_flt,
    output logic                o_wr_ack,
    output logic                o_rd_ack,
    output reg_data_t           o_rdata,
    output logic                o_addr_err,
    output logic                o_dgt_ang_pwm_en,
    output logic                o_intb_n,
    output ctrl_st_e            o_ctrl_st
);

    flt_vec_t   flt_filt;
    flt_vec_t   flt_latched;
    flt_vec_t   flt_mask;
    reg_mode_t  reg_mode;

    reg_access_if acc_if ();
    reg_rsp_if    rsp_if ();

    // ==================================================
    // decode -> execute -> result
    // ==================================================
    hv_reg_decode u_reg_decode (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wr_req   (i_wr_req),
        .i_rd_req   (i_rd_req),
        .i_addr     (i_addr),
        .i_wdata    (i_wdata),
        .o_acc      (acc_if.decode)
    );

    hv_fault_filter #(
        .FLT_FILT_CYC   (FLT_FILT_CYC)
    ) u_fault_filter (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_hv_vcc_uv    (i_hv_vcc_uv),
        .i_hv_vcc_ov    (i_hv_vcc_ov),
        .i_hv_ot        (i_hv_ot),
        .i_hv_oc        (i_hv_oc),
        .i_hv_desat_flt (i_hv_desat_flt),
        .i_hv_scp_flt   (i_hv_scp_flt),
        .o_flt          (flt_filt)
    );

    hv_reg_bank u_reg_bank (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_acc          (acc_if.bank),
        .i_flt          (flt_filt),
        .i_ctrl_st      (o_ctrl_st),
        .o_rsp          (rsp_if.bank),
        .o_mode         (reg_mode),
        .o_flt_latched  (flt_latched),
        .o_flt_mask     (flt_mask)
    );

    hv_ctrl_fsm u_ctrl_fsm (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_mode         (reg_mode),
        .i_flt_latched  (flt_latched),
        .o_ctrl_st      (o_ctrl_st),
        .o_pwm_en       (o_dgt_ang_pwm_en)
    );

    hv_rsp_result u_rsp_result (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rsp          (rsp_if.result),
        .i_flt_latched  (flt_latched),
        .i_flt_mask     (flt_mask),
        .o_wr_ack       (o_wr_ack),
        .o_rd_ack       (o_rd_ack),
        .o_rdata        (o_rdata),
        .o_addr_err     (o_addr_err),
        .o_intb_n       (o_intb_n)
    );

endmodule

// File: verification/hv_core_assertions.sv
`timescale 1ns/1ps

module hv_core_assertions import hv_ctrl_pkg::*; (
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_wr_req,
    input  logic        i_rd_req,
    input  logic        i_wr_ack,
    input  logic        i_rd_ack,
    input  logic        i_pwm_en,
    input  ctrl_st_e    i_ctrl_st
);

    int fail_cnt = 0;   // failed assertion count

    // ==================================================
    // request to ack latency
    // ==================================================
    a_wr_lat: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wr_req |-> ##3 i_wr_ack)
        else begin
            fail_cnt++;
            $error("write ack did not follow its request by 3 cycles");
        end

    a_rd_lat: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_rd_req && !i_wr_req) |-> ##3 i_rd_ack)  // write wins
        else begin
            fail_cnt++;
            $error("read ack did not follow its request by 3 cycles");
        end

    a_ack_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_wr_ack && i_rd_ack))
        else begin
            fail_cnt++;
            $error("write and read ack high together");
        end

    a_pwm_st: assert property (@(posedge i_clk) disable iff (i_reset)
        i_pwm_en |-> i_ctrl_st == ST_NORMAL)
        else begin
            fail_cnt++;
            $error("pwm enabled outside normal state");
        end

endmodule

bind hv_core hv_core_assertions u_assertions (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_wr_req   (i_wr_req),
    .i_rd_req   (i_rd_req),
    .i_wr_ack   (o_wr_ack),
    .i_rd_ack   (o_rd_ack),
    .i_pwm_en   (o_dgt_ang_pwm_en),
    .i_ctrl_st  (o_ctrl_st)
);

// File: verification/hv_core_tb.sv
`timescale 1ns/1ps

module hv_core_tb import hv_reg_pkg::*; import hv_ctrl_pkg::*; ();

    localparam int FILT_CYC = 4;
    localparam int REQ_LAT  = 3;    // request edge to ack

    typedef enum {OP_WR, OP_RD, OP_FLT, OP_WAIT} op_e;

    typedef struct {
        op_e                op;
        logic [REG_AW-1:0]  addr;
        reg_data_t          data;
        flt_vec_t           flt;
        int                 hold;   // idle cycles after the row
        reg_data_t          exp_data;
        logic               exp_err;
        ctrl_st_e           exp_st;
        logic               exp_intb_n;
    } row_t;

    typedef struct {
        int         row;
        int         due;
        logic       is_rd;
        reg_data_t  exp_data;
        logic       exp_err;
    } pend_t;

    logic               clk;
    logic               rst;
    logic               wr_req;
    logic               rd_req;
    logic [REG_AW-1:0]  addr;
    reg_data_t          wdata;
    flt_vec_t           flt_in;
    logic               wr_ack;
    logic               rd_ack;
    reg_data_t          rdata;
    logic               addr_err;
    logic               pwm_en;
    logic               intb_n;
    ctrl_st_e           ctrl_st;

    row_t   tbl[$];
    pend_t  pend[$];    // requests waiting for their ack
    int     seed = 83281;
    int     cyc = 0;
    int     errors = 0;
    int     n_pass = 0;
    int     n_fail = 0;
    logic   tbl_ready = 1'b0;

    hv_core #(
        .FLT_FILT_CYC       (FILT_CYC)
    ) dut (
        .i_clk              (clk),
        .i_reset            (rst),
        .i_wr_req           (wr_req),
        .i_rd_req           (rd_req),
        .i_addr             (addr),
        .i_wdata            (wdata),
        .i_hv_vcc_uv        (flt_in[FLT_VCC_UV]),
        .i_hv_vcc_ov        (flt_in[FLT_VCC_OV]),
        .i_hv_ot            (flt_in[FLT_OT]),
        .i_hv_oc            (flt_in[FLT_OC]),
        .i_hv_desat_flt     (flt_in[FLT_DESAT]),
        .i_hv_scp_flt       (flt_in[FLT_SCP]),
        .o_wr_ack           (wr_ack),
        .o_rd_ack           (rd_ack),
        .o_rdata            (rdata),
        .o_addr_err         (addr_err),
        .o_dgt_ang_pwm_en   (pwm_en),
        .o_intb_n           (intb_n),
        .o_ctrl_st          (ctrl_st)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_state(input ctrl_st_e got, input ctrl_st_e exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    // faults sit in status bits 7:2
    function automatic reg_data_t status_bits(input flt_vec_t f);
        return {f, 2'b00};
    endfunction

    // state sits in ctrl state bits 7:4
    function automatic reg_data_t ctrl_rd(input ctrl_st_e s);
        return {s, 4'b0000};
    endfunction

    task automatic add_row(input op_e op, input logic [REG_AW-1:0] a, input reg_data_t d,
                           input flt_vec_t f, input int hold, input reg_data_t exp_data,
                           input logic exp_err, input ctrl_st_e exp_st, input logic exp_intb_n);
        row_t r;
        r = '{op, a, d, f, hold, exp_data, exp_err, exp_st, exp_intb_n};
        tbl.push_back(r);
    endtask

    task automatic add_write(input logic [REG_AW-1:0] a, input reg_data_t d, input logic err);
        add_row(OP_WR, a, d, '0, 0, 8'h00, err, ST_RESET, 1'b1);
    endtask

    task automatic add_read(input logic [REG_AW-1:0] a, input reg_data_t exp, input logic err);
        add_row(OP_RD, a, 8'h00, '0, 0, exp, err, ST_RESET, 1'b1);
    endtask

    task automatic add_fault(input flt_vec_t f, input int hold);
        add_row(OP_FLT, '0, 8'h00, f, hold, 8'h00, 1'b0, ST_RESET, 1'b1);
    endtask

    task automatic add_wait(input int hold, input ctrl_st_e st, input logic intb);
        add_row(OP_WAIT, '0, 8'h00, '0, hold, 8'h00, 1'b0, st, intb);
    endtask

    // ==================================================
    // stimulus table
    // ==================================================
    task automatic build_table();
        reg_data_t  scr;
        reg_data_t  cfg;
        flt_vec_t   f_ot;
        flt_vec_t   f_oc;
        flt_vec_t   f_ds;
        scr  = reg_data_t'($random(seed));
        cfg  = reg_data_t'($random(seed));
        f_ot = flt_vec_t'(1) << FLT_OT;
        f_oc = flt_vec_t'(1) << FLT_OC;
        f_ds = flt_vec_t'(1) << FLT_DESAT;
        add_wait(2, ST_WAIT, 1'b1);
        add_read(ADDR_MODE, 8'h00, 1'b0);
        add_read(ADDR_COM_CFG, 8'h00, 1'b0);
        add_read(ADDR_STATUS_FLT, 8'h00, 1'b0);
        add_read(ADDR_CTRL_ST, ctrl_rd(ST_WAIT), 1'b0);
        add_read(ADDR_SCRATCH, 8'h00, 1'b0);
        add_write(ADDR_SCRATCH, scr, 1'b0);     // back to back
        add_write(ADDR_COM_CFG, cfg, 1'b0);
        add_read(ADDR_SCRATCH, scr, 1'b0);
        add_read(ADDR_COM_CFG, cfg, 1'b0);
        add_read(4'hA, 8'h00, 1'b1);            // unmapped
        add_write(ADDR_CTRL_ST, 8'hFF, 1'b1);
        add_write(4'hF, 8'h5A, 1'b1);
        add_read(ADDR_MODE, 8'h00, 1'b0);
        add_read(ADDR_SCRATCH, scr, 1'b0);
        add_read(ADDR_CTRL_ST, ctrl_rd(ST_WAIT), 1'b0);
        add_write(ADDR_COM_CFG, 8'h00, 1'b0);
        add_write(ADDR_MODE, 8'h02, 1'b0);      // cfg_en
        add_wait(5, ST_CFG, 1'b1);
        add_read(ADDR_CTRL_ST, ctrl_rd(ST_CFG), 1'b0);
        add_write(ADDR_MODE, 8'h03, 1'b0);      // cfg_en and normal_en
        add_wait(5, ST_NORMAL, 1'b1);
        add_read(ADDR_CTRL_ST, ctrl_rd(ST_NORMAL), 1'b0);
        add_read(ADDR_MODE, 8'h03, 1'b0);
        add_fault(f_ot, 10);
        add_fault('0, 0);
        add_wait(4, ST_FAULT, 1'b0);
        add_read(ADDR_STATUS_FLT, status_bits(f_ot), 1'b0);
        add_write(ADDR_COM_CFG, reg_data_t'(f_ot), 1'b0);  // mask it
        add_wait(4, ST_FAULT, 1'b1);
        add_write(ADDR_COM_CFG, 8'h00, 1'b0);
        add_wait(4, ST_FAULT, 1'b0);
        add_write(ADDR_STATUS_FLT, status_bits(f_ot), 1'b0);
        add_wait(4, ST_NORMAL, 1'b1);
        add_read(ADDR_STATUS_FLT, 8'h00, 1'b0);
        add_fault(f_oc, FILT_CYC - 1);          // glitch shorter than the filter
        add_fault('0, 8);
        add_wait(2, ST_NORMAL, 1'b1);
        add_read(ADDR_STATUS_FLT, 8'h00, 1'b0);
        add_fault(f_ds, 10);                    // stays high
        add_write(ADDR_STATUS_FLT, status_bits(f_ds), 1'b0);
        add_read(ADDR_STATUS_FLT, status_bits(f_ds), 1'b0);   // bank cycle right after clear
        add_wait(4, ST_FAULT, 1'b0);
        add_fault('0, 6);
        add_write(ADDR_STATUS_FLT, status_bits(f_ds), 1'b0);
        add_wait(4, ST_NORMAL, 1'b1);
        add_read(ADDR_STATUS_FLT, 8'h00, 1'b0);
        add_wait(6, ST_NORMAL, 1'b1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_row(input int idx, input int err_before);
        if (errors == err_before) begin
            n_pass++;
            $display("test %0d %s ok", idx, tbl[idx].op.name());
        end else begin
            n_fail++;
            $display("test %0d %s: %0d errors", idx, tbl[idx].op.name(), errors - err_before);
        end
    endtask

    task automatic apply_row(input int idx);
        row_t   r;
        pend_t  p;
        int     err_before;
        r = tbl[idx];
        err_before = errors;
        case (r.op)
            OP_WR, OP_RD: begin
                wr_req = (r.op == OP_WR);
                rd_req = (r.op == OP_RD);
                addr   = r.addr;
                wdata  = r.data;
                p = '{idx, cyc + REQ_LAT, r.op == OP_RD, r.exp_data, r.exp_err};
                pend.push_back(p);
                next_cycle();
                wr_req = 1'b0;
                rd_req = 1'b0;
                repeat (r.hold) next_cycle();
            end
            OP_FLT: begin
                flt_in = r.flt;
                repeat (r.hold) next_cycle();
                report_row(idx, err_before);
            end
            default: begin
                repeat (r.hold) next_cycle();
                check_state(ctrl_st, r.exp_st, "o_ctrl_st");
                check_flag(pwm_en, r.exp_st == ST_NORMAL, "o_dgt_ang_pwm_en");
                check_flag(intb_n, r.exp_intb_n, "o_intb_n");
                report_row(idx, err_before);
            end
        endcase
    endtask

    // ==================================================
    // ack monitor sampled mid cycle
    // ==================================================
    always @(negedge clk) begin : ack_monitor
        pend_t  p;
        int     err_before;
        if (!rst) begin
            if (pend.size() != 0 && pend[0].due == cyc) begin
                p = pend.pop_front();
                err_before = errors;
                if (p.is_rd ? !(rd_ack && !wr_ack) : !(wr_ack && !rd_ack)) begin
                    errors++;
                    $display("test %0d: no %s acknowledge 3 cycles after the request", p.row,
                             p.is_rd ? "read" : "write");
                end else begin
                    if (p.is_rd)
                        check_data(rdata, p.exp_data, "o_rdata");
                    check_flag(addr_err, p.exp_err, "o_addr_err");
                end
                report_row(p.row, err_before);
            end else if (wr_ack || rd_ack) begin
                errors++;
                $display("acknowledge at %0t with no request due", $time);
            end
        end
    end

    initial begin : watchdog
        wait (tbl_ready);
        repeat (tbl.size() * 40) @(posedge clk);
        $display("watchdog expired before the test table finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst    = 1'b1;
        wr_req = 1'b0;
        rd_req = 1'b0;
        addr   = '0;
        wdata  = '0;
        flt_in = '0;
        build_table();
        tbl_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (tbl[i]) apply_row(i);
        while (pend.size() != 0) next_cycle();
        next_cycle();
        if (dut.u_assertions.fail_cnt != 0) begin
            errors += dut.u_assertions.fail_cnt;
            $display("%0d assertion failures in the bound checker", dut.u_assertions.fail_cnt);
        end
        $display("tests: %0d ok, %0d with errors, %0d errors total", n_pass, n_fail, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: flist.f
logic/hv_reg_pkg.sv
logic/hv_ctrl_pkg.sv
logic/hv_core_if.sv
logic/hv_reg_decode.sv
logic/hv_fault_filter.sv
logic/hv_reg_bank.sv
logic/hv_ctrl_fsm.sv
logic/hv_rsp_result.sv
logic/hv_core.sv
verification/hv_core_assertions.sv
verification/hv_core_tb.sv

// File: Bender.yml
package:
  name: hv_core

sources:
  - logic/hv_reg_pkg.sv
  - logic/hv_ctrl_pkg.sv
  - logic/hv_core_if.sv
  - logic/hv_reg_decode.sv
  - logic/hv_fault_filter.sv
  - logic/hv_reg_bank.sv
  - logic/hv_ctrl_fsm.sv
  - logic/hv_rsp_result.sv
  - logic/hv_core.sv
  - target: simulation
    files:
      - verification/hv_core_assertions.sv
      - verification/hv_core_tb.sv
